// File: logic/hbm_ctrl_pkg.sv
package hbm_ctrl_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [31:0] port_mask_t;  // One enable per memory port
    typedef logic [3:0]  burst_len_t;
    typedef logic [2:0]  access_mode_t;
    typedef logic [10:0] drp_addr_t;
    typedef logic [15:0] drp_data_t;

    typedef enum logic [1:0] {CLK_650, CLK_450, CLK_325} clk_profile_t;

    localparam access_mode_t MODE_READ         = 3'd0;
    localparam access_mode_t MODE_WRITE        = 3'd1;
    localparam access_mode_t MODE_QUEUED_READ  = 3'd3;
    localparam access_mode_t MODE_QUEUED_WRITE = 3'd4;

    localparam burst_len_t DEFAULT_LENGTH = 4'd15;

    ////////////////////////////////////////////////////////////
    // Serial timing

    localparam int CLKS_PER_BIT = 16;
    localparam int TICK_W = $clog2(CLKS_PER_BIT);
    typedef logic [TICK_W-1:0] tick_t;

    ////////////////////////////////////////////////////////////
    // Command and reply bytes

    localparam byte_t CMD_START        = 8'h30;
    localparam byte_t CMD_STOP         = 8'h31;
    localparam byte_t CMD_WRITE_MODE   = 8'h32;
    localparam byte_t CMD_READ_MODE    = 8'h33;
    localparam byte_t CMD_QUEUED_READ  = 8'h35;
    localparam byte_t CMD_QUEUED_WRITE = 8'h36;
    localparam byte_t CMD_INC_ON       = 8'h37;
    localparam byte_t CMD_INC_OFF      = 8'h38;
    localparam byte_t CMD_PORTS        = 8'h39;  // Four data bytes follow
    localparam byte_t CMD_LENGTH       = 8'h3A;  // One data byte follows
    localparam byte_t CMD_CLK_650      = 8'h3C;
    localparam byte_t CMD_CLK_450      = 8'h3D;
    localparam byte_t CMD_CLK_325      = 8'h3E;
    localparam byte_t CMD_RESET        = 8'h40;

    localparam byte_t RPL_START        = 8'h41;
    localparam byte_t RPL_STOP         = 8'h42;
    localparam byte_t RPL_WRITE_MODE   = 8'h43;
    localparam byte_t RPL_READ_MODE    = 8'h44;
    localparam byte_t RPL_QUEUED_READ  = 8'h46;
    localparam byte_t RPL_QUEUED_WRITE = 8'h47;
    localparam byte_t RPL_INC_ON       = 8'h48;
    localparam byte_t RPL_INC_OFF      = 8'h49;
    localparam byte_t RPL_PORTS        = 8'h4A;
    localparam byte_t RPL_RESET        = 8'h4B;
    localparam byte_t RPL_LENGTH       = 8'h4C;
    localparam byte_t RPL_CLK_650      = 8'h4E;
    localparam byte_t RPL_CLK_450      = 8'h4F;
    localparam byte_t RPL_CLK_325      = 8'h50;

    ////////////////////////////////////////////////////////////
    // Clock generator reprogramming

    localparam int DRP_WRITES = 13;
    typedef logic [$clog2(DRP_WRITES)-1:0] drp_idx_t;

    localparam drp_addr_t DRP_ADDR_TABLE [DRP_WRITES] = '{
        11'h304, 11'h308, 11'h30C, 11'h310, 11'h33C, 11'h340, 11'h344,
        11'h348, 11'h34C, 11'h350, 11'h354, 11'h358, 11'h35C
    };

    // Rows follow clk_profile_t order and the last word starts the reconfig
    localparam drp_data_t DRP_DATA_TABLE [3][DRP_WRITES] = '{
        '{16'h1041, 16'h0000, 16'h1105, 16'h0080, 16'h1041, 16'h1187, 16'h0080,
          16'h02EE, 16'h7C01, 16'h7FE9, 16'h0900, 16'h8890, 16'h0003},
        '{16'h1041, 16'h0000, 16'h1105, 16'h0080, 16'h1041, 16'h1105, 16'h0080,
          16'h03E8, 16'h6401, 16'h67E9, 16'h0900, 16'h1890, 16'h0003},
        '{16'h1082, 16'h0000, 16'h1249, 16'h0000, 16'h1041, 16'h1187, 16'h0080,
          16'h02EE, 16'h7C01, 16'h7FE9, 16'h0900, 16'h8890, 16'h0003}
    };

endpackage

// File: logic/uart_receiver.sv
module uart_receiver
(
    input  logic                clk,
    input  logic                reset_state_machine,
    input  logic                usb_uart_rx,
    output hbm_ctrl_pkg::byte_t rx_byte,
    output logic                rx_valid
);
    import hbm_ctrl_pkg::*;

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t  rx_state;
    logic       rx_meta;
    logic       rx_sync;
    tick_t      tick;
    logic [2:0] bit_idx;
    byte_t      rx_shift;

    // Line idles high
    always_ff @(posedge clk)
    begin
        if (reset_state_machine)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end
        else
        begin
            rx_meta <= usb_uart_rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk)
    begin
        rx_valid <= 1'b0;
        if (reset_state_machine)
        begin
            rx_state <= RX_IDLE;
            tick <= '0;
            bit_idx <= '0;
        end
        else
        begin
            tick <= tick + 1'b1;
            case (rx_state)
                RX_IDLE:
                begin
                    tick <= '0;
                    bit_idx <= '0;
                    if (!rx_sync)
                        rx_state <= RX_START;
                end
                RX_START:
                    if (tick == tick_t'(CLKS_PER_BIT / 2 - 1))  // Mid start bit
                    begin
                        tick <= '0;
                        rx_state <= rx_sync ? RX_IDLE : RX_DATA;
                    end
                RX_DATA:
                    if (tick == tick_t'(CLKS_PER_BIT - 1))
                    begin
                        rx_shift <= {rx_sync, rx_shift[7:1]};  // LSB first
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            rx_state <= RX_STOP;
                    end
                RX_STOP:
                    if (tick == tick_t'(CLKS_PER_BIT - 1))
                    begin
                        rx_byte <= rx_shift;
                        rx_valid <= rx_sync;  // Low stop bit loses the byte
                        rx_state <= RX_IDLE;
                    end
            endcase
        end
    end

endmodule

// File: logic/settings_registers.sv
module settings_registers
(
    input  logic                       clk,
    input  logic                       reset_state_machine,
    input  logic                       rx_valid,
    input  hbm_ctrl_pkg::byte_t        rx_byte,
    input  logic                       reconfig_busy,
    output logic                       collecting,
    output logic                       start,
    output logic                       address_inc,
    output hbm_ctrl_pkg::access_mode_t read_write,
    output hbm_ctrl_pkg::port_mask_t   port_mask,
    output hbm_ctrl_pkg::burst_len_t   length,
    output hbm_ctrl_pkg::byte_t        settings_reply,
    output logic                       settings_reply_valid
);
    import hbm_ctrl_pkg::*;

    typedef enum logic [1:0] {SET_IDLE, SET_MASK_BYTE, SET_LENGTH_BYTE} set_state_t;

    set_state_t settings_state;
    logic [1:0] mask_cnt;
    port_mask_t mask_stage;
    logic       accept;
    logic       restore;
    logic       cmd_hit;
    byte_t      cmd_reply;

    assign accept     = rx_valid && !reconfig_busy;
    assign collecting = (settings_state != SET_IDLE);
    assign restore    = reset_state_machine
        || (accept && settings_state == SET_IDLE && rx_byte == CMD_RESET);

    // Single-byte commands answered at once
    always_comb
    begin
        cmd_hit = 1'b1;
        cmd_reply = RPL_RESET;
        case (rx_byte)
            CMD_START:        cmd_reply = RPL_START;
            CMD_STOP:         cmd_reply = RPL_STOP;
            CMD_WRITE_MODE:   cmd_reply = RPL_WRITE_MODE;
            CMD_READ_MODE:    cmd_reply = RPL_READ_MODE;
            CMD_QUEUED_READ:  cmd_reply = RPL_QUEUED_READ;
            CMD_QUEUED_WRITE: cmd_reply = RPL_QUEUED_WRITE;
            CMD_INC_ON:       cmd_reply = RPL_INC_ON;
            CMD_INC_OFF:      cmd_reply = RPL_INC_OFF;
            CMD_RESET:        cmd_reply = RPL_RESET;
            default:          cmd_hit = 1'b0;  // Clock, multi-byte and unknown
        endcase
    end

    always_ff @(posedge clk)
    begin
        settings_reply_valid <= 1'b0;
        if (reset_state_machine)
        begin
            settings_state <= SET_IDLE;
            mask_cnt <= '0;
        end
        else if (accept)
        begin
            case (settings_state)
                SET_IDLE:
                begin
                    settings_reply <= cmd_reply;
                    settings_reply_valid <= cmd_hit;
                    case (rx_byte)
                        CMD_START:        start <= 1'b1;
                        CMD_STOP:         start <= 1'b0;
                        CMD_WRITE_MODE:   read_write <= MODE_WRITE;
                        CMD_READ_MODE:    read_write <= MODE_READ;
                        CMD_QUEUED_READ:  read_write <= MODE_QUEUED_READ;
                        CMD_QUEUED_WRITE: read_write <= MODE_QUEUED_WRITE;
                        CMD_INC_ON:       address_inc <= 1'b1;
                        CMD_INC_OFF:      address_inc <= 1'b0;
                        CMD_PORTS:
                        begin
                            mask_cnt <= '0;
                            settings_state <= SET_MASK_BYTE;
                        end
                        CMD_LENGTH:       settings_state <= SET_LENGTH_BYTE;
                        default:          ;
                    endcase
                end

                ////////////////////////////////////////////////////////////
                // Data bytes

                SET_MASK_BYTE:
                begin
                    mask_stage <= {mask_stage[23:0], rx_byte};  // First byte ends up on top
                    mask_cnt <= mask_cnt + 1'b1;
                    if (mask_cnt == 2'd3)
                    begin
                        port_mask <= {mask_stage[23:0], rx_byte};
                        settings_reply <= RPL_PORTS;
                        settings_reply_valid <= 1'b1;
                        settings_state <= SET_IDLE;
                    end
                end
                SET_LENGTH_BYTE:
                begin
                    length <= rx_byte[3:0];
                    settings_reply <= RPL_LENGTH;
                    settings_reply_valid <= 1'b1;
                    settings_state <= SET_IDLE;
                end
                default:
                    settings_state <= SET_IDLE;
            endcase
        end

        // Power-up values that the reset command also restores
        if (restore)
        begin
            start <= 1'b0;
            read_write <= MODE_READ;
            address_inc <= 1'b0;
            port_mask <= '0;
            length <= DEFAULT_LENGTH;
        end
    end

endmodule

// File: logic/clock_reconfig_sequencer.sv
module clock_reconfig_sequencer
(
    input  logic                    clk,
    input  logic                    reset_state_machine,
    input  logic                    rx_valid,
    input  hbm_ctrl_pkg::byte_t     rx_byte,
    input  logic                    collecting,
    input  logic                    transaction_complete,
    input  logic                    clk_locked,
    output logic                    reconfig_busy,
    output hbm_ctrl_pkg::drp_addr_t clk_addr,
    output hbm_ctrl_pkg::drp_data_t clk_data,
    output logic                    transact,
    output hbm_ctrl_pkg::byte_t     clock_reply,
    output logic                    clock_reply_valid
);
    import hbm_ctrl_pkg::*;

    typedef enum logic [1:0] {SEQ_IDLE, SEQ_WRITE, SEQ_GAP, SEQ_LOCK_WAIT} seq_state_t;

    seq_state_t   seq_state;
    clk_profile_t profile;
    drp_idx_t     write_idx;
    logic         cmd_hit;
    clk_profile_t cmd_profile;
    byte_t        cmd_reply;

    always_comb
    begin
        cmd_hit = 1'b1;
        cmd_profile = CLK_650;
        cmd_reply = RPL_CLK_650;
        case (rx_byte)
            CMD_CLK_650: ;
            CMD_CLK_450:
            begin
                cmd_profile = CLK_450;
                cmd_reply = RPL_CLK_450;
            end
            CMD_CLK_325:
            begin
                cmd_profile = CLK_325;
                cmd_reply = RPL_CLK_325;
            end
            default:
                cmd_hit = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        clock_reply_valid <= 1'b0;
        if (reset_state_machine)
        begin
            seq_state <= SEQ_IDLE;
            profile <= CLK_650;
            write_idx <= '0;
            reconfig_busy <= 1'b0;
            transact <= 1'b0;
        end
        else
        begin
            case (seq_state)
                SEQ_IDLE:
                    if (rx_valid && cmd_hit && !collecting)  // Not a mask or length data byte
                    begin
                        profile <= cmd_profile;
                        write_idx <= '0;
                        clock_reply <= cmd_reply;
                        clock_reply_valid <= 1'b1;
                        reconfig_busy <= 1'b1;
                        seq_state <= SEQ_GAP;
                    end
                SEQ_GAP:
                begin
                    clk_addr <= DRP_ADDR_TABLE[write_idx];
                    clk_data <= DRP_DATA_TABLE[profile][write_idx];
                    transact <= 1'b1;
                    seq_state <= SEQ_WRITE;
                end
                // Request held until the port answers
                SEQ_WRITE:
                    if (transaction_complete)
                    begin
                        transact <= 1'b0;
                        write_idx <= write_idx + 1'b1;
                        if (write_idx == drp_idx_t'(DRP_WRITES - 1))
                            seq_state <= SEQ_LOCK_WAIT;
                        else
                            seq_state <= SEQ_GAP;
                    end
                SEQ_LOCK_WAIT:
                    if (clk_locked)
                    begin
                        reconfig_busy <= 1'b0;
                        seq_state <= SEQ_IDLE;
                    end
            endcase
        end
    end

endmodule

// File: logic/reply_transmitter.sv
module reply_transmitter
(
    input  logic                clk,
    input  logic                reset_state_machine,
    input  logic                settings_reply_valid,
    input  hbm_ctrl_pkg::byte_t settings_reply,
    input  logic                clock_reply_valid,
    input  hbm_ctrl_pkg::byte_t clock_reply,
    output logic                usb_uart_tx
);
    import hbm_ctrl_pkg::*;

    logic       in_valid;
    byte_t      in_byte;
    logic       pend_valid;
    byte_t      pend_byte;
    logic [8:0] tx_shift;   // Data bits, then stop bit
    logic [3:0] bits_left;  // Bits of the frame still on the line
    tick_t      tick;
    logic       bit_end;
    logic       load_frame;

    // Only one part answers a given byte
    assign in_valid   = settings_reply_valid || clock_reply_valid;
    assign in_byte    = settings_reply_valid ? settings_reply : clock_reply;
    assign bit_end    = (bits_left != '0) && (tick == tick_t'(CLKS_PER_BIT - 1));
    assign load_frame = (bits_left == '0) && (pend_valid || in_valid);

    always_ff @(posedge clk)
    begin
        if (in_valid)
            pend_byte <= in_byte;
        if (load_frame)
            tx_shift <= {1'b1, pend_valid ? pend_byte : in_byte};
        else if (bit_end)
            tx_shift <= {1'b1, tx_shift[8:1]};  // Fill with idle level
    end

    always_ff @(posedge clk)
    begin
        if (reset_state_machine)
        begin
            usb_uart_tx <= 1'b1;
            pend_valid <= 1'b0;
            bits_left <= '0;
            tick <= '0;
        end
        else if (load_frame)
        begin
            usb_uart_tx <= 1'b0;  // Start bit
            bits_left <= 4'd10;
            tick <= '0;
            pend_valid <= pend_valid && in_valid;
        end
        else
        begin
            if (in_valid)
                pend_valid <= 1'b1;  // Overwrites an older pending reply
            if (bits_left != '0)
                tick <= tick + 1'b1;
            if (bit_end)
            begin
                usb_uart_tx <= tx_shift[0];
                bits_left <= bits_left - 1'b1;
            end
        end
    end

endmodule

// File: logic/hbm_test_controller.sv
module hbm_test_controller
(
    input  logic                       clk,
    input  logic                       reset_state_machine,
    input  logic                       usb_uart_rx,
    input  logic                       transaction_complete,
    input  logic                       clk_locked,
    output logic                       usb_uart_tx,
    output logic                       start,
    output logic                       address_inc,
    output hbm_ctrl_pkg::access_mode_t read_write,
    output hbm_ctrl_pkg::port_mask_t   port_mask,
    output hbm_ctrl_pkg::burst_len_t   length,
    output hbm_ctrl_pkg::drp_addr_t    clk_addr,
    output hbm_ctrl_pkg::drp_data_t    clk_data,
    output logic                       transact
);
    import hbm_ctrl_pkg::*;

    byte_t rx_byte;
    logic  rx_valid;
    logic  collecting;
    logic  reconfig_busy;
    byte_t settings_reply;
    logic  settings_reply_valid;
    byte_t clock_reply;
    logic  clock_reply_valid;

    uart_receiver i_uart_receiver
    (
        .clk                  (clk),
        .reset_state_machine  (reset_state_machine),
        .usb_uart_rx          (usb_uart_rx),
        .rx_byte              (rx_byte),
        .rx_valid             (rx_valid)
    );

    ////////////////////////////////////////////////////////////
    // Command parts side by side on the received bytes

    settings_registers i_settings_registers
    (
        .clk                  (clk),
        .reset_state_machine  (reset_state_machine),
        .rx_valid             (rx_valid),
        .rx_byte              (rx_byte),
        .reconfig_busy        (reconfig_busy),
        .collecting           (collecting),
        .start                (start),
        .address_inc          (address_inc),
        .read_write           (read_write),
        .port_mask            (port_mask),
        .length               (length),
        .settings_reply       (settings_reply),
        .settings_reply_valid (settings_reply_valid)
    );

    clock_reconfig_sequencer i_clock_reconfig_sequencer
    (
        .clk                  (clk),
        .reset_state_machine  (reset_state_machine),
        .rx_valid             (rx_valid),
        .rx_byte              (rx_byte),
        .collecting           (collecting),
        .transaction_complete (transaction_complete),
        .clk_locked           (clk_locked),
        .reconfig_busy        (reconfig_busy),
        .clk_addr             (clk_addr),
        .clk_data             (clk_data),
        .transact             (transact),
        .clock_reply          (clock_reply),
        .clock_reply_valid    (clock_reply_valid)
    );

    reply_transmitter i_reply_transmitter
    (
        .clk                  (clk),
        .reset_state_machine  (reset_state_machine),
        .settings_reply_valid (settings_reply_valid),
        .settings_reply       (settings_reply),
        .clock_reply_valid    (clock_reply_valid),
        .clock_reply          (clock_reply),
        .usb_uart_tx          (usb_uart_tx)
    );

endmodule

// File: tb/reply_checker.sv
module reply_checker
(
    input  logic                       clk,
    input  logic                       reset_state_machine,
    input  logic                       usb_uart_tx,
    input  logic                       transact,
    input  hbm_ctrl_pkg::drp_addr_t    clk_addr,
    input  hbm_ctrl_pkg::drp_data_t    clk_data,
    input  logic                       start,
    input  logic                       address_inc,
    input  hbm_ctrl_pkg::access_mode_t read_write,
    input  hbm_ctrl_pkg::port_mask_t   port_mask,
    input  hbm_ctrl_pkg::burst_len_t   length
);
    timeunit 1ns;
    timeprecision 100ps;
    import hbm_ctrl_pkg::*;

    localparam int BIT_CLKS    = 16;
    localparam int REPLY_LIMIT = 40 * BIT_CLKS;  // Cycles
    localparam int WRITE_LIMIT = 400;

    int        mismatch_count = 0;
    int        lost_count = 0;
    byte_t     expected_replies [$];
    drp_addr_t write_addrs [$];
    drp_data_t write_words [$];
    logic      transact_q = 1'b0;

    ////////////////////////////////////////////////////////////
    // Reply line decoder sampled on the falling edge

    initial
    begin : decode_replies
        byte_t rx;
        int    i;
        forever
        begin
            @(negedge clk);
            if (!reset_state_machine && usb_uart_tx === 1'b0)
            begin
                repeat (BIT_CLKS / 2) @(negedge clk);  // Mid start bit
                if (usb_uart_tx !== 1'b0)
                begin
                    $display("Reply line dropped low at %0d ns without a full start bit", $time);
                    lost_count++;
                end
                else
                begin
                    for (i = 0; i < 8; i++)
                    begin
                        repeat (BIT_CLKS) @(negedge clk);
                        rx[i] = usb_uart_tx;  // LSB first
                    end
                    repeat (BIT_CLKS) @(negedge clk);
                    if (usb_uart_tx !== 1'b1)
                    begin
                        $display("Reply frame at %0d ns has a low stop bit", $time);
                        lost_count++;
                    end
                    take_reply(rx);
                end
            end
        end
    end

    task automatic take_reply(input byte_t got);
        byte_t want;
        if (expected_replies.size() == 0)
        begin
            $display("Unexpected reply byte 0x%02h arrived at %0d ns", got, $time);
            lost_count++;
        end
        else
        begin
            want = expected_replies.pop_front();
            if (got !== want)
            begin
                $display("CHECK FAILED at %0d ns: reply 0x%02h, expected 0x%02h",
                         $time, got, want);
                mismatch_count++;
            end
        end
    endtask

    // Each new register-port request is logged with its address and word
    always @(negedge clk)
    begin
        if (transact === 1'b1 && transact_q !== 1'b1)
        begin
            write_addrs.push_back(clk_addr);
            write_words.push_back(clk_data);
        end
        transact_q = transact;
    end

    ////////////////////////////////////////////////////////////
    // Called from the trace runner

    task automatic expect_reply(input byte_t value);
        expected_replies.push_back(value);
    endtask

    task automatic wait_replies(output bit timed_out);
        int waited;
        waited = 0;
        while (expected_replies.size() != 0 && waited < REPLY_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        timed_out = (expected_replies.size() != 0);
    endtask

    task automatic check_write(input drp_addr_t addr, input drp_data_t data,
                               output bit timed_out);
        int        waited;
        drp_addr_t got_addr;
        drp_data_t got_data;
        waited = 0;
        while (write_addrs.size() == 0 && waited < WRITE_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        timed_out = (write_addrs.size() == 0);
        if (!timed_out)
        begin
            got_addr = write_addrs.pop_front();
            got_data = write_words.pop_front();
            if (got_addr !== addr || got_data !== data)
            begin
                $display("CHECK FAILED at %0d ns: write 0x%03h=0x%04h, expected 0x%03h=0x%04h",
                         $time, got_addr, got_data, addr, data);
                mismatch_count++;
            end
        end
    endtask

    task automatic check_settings(input logic exp_start, input access_mode_t exp_mode,
                                  input logic exp_inc, input port_mask_t exp_mask,
                                  input burst_len_t exp_len);
        if (start !== exp_start || read_write !== exp_mode || address_inc !== exp_inc
            || port_mask !== exp_mask || length !== exp_len)
        begin
            $display("CHECK FAILED at %0d ns: settings %0b %0d %0b %08h %0d",
                     $time, start, read_write, address_inc, port_mask, length);
            $display("    expected %0b %0d %0b %08h %0d",
                     exp_start, exp_mode, exp_inc, exp_mask, exp_len);
            mismatch_count++;
        end
    endtask

    task automatic report_leftovers();
        drp_data_t word;
        while (write_addrs.size() != 0)
        begin
            word = write_words.pop_front();
            $display("Extra register-port write 0x%03h=0x%04h that the trace does not list",
                     write_addrs.pop_front(), word);
            lost_count++;
        end
    endtask

endmodule

// File: tb/tb_top.sv
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;
    import hbm_ctrl_pkg::*;

    localparam int          BIT_CLKS = 16;     // Host bit time in clocks
    localparam int          WRITES_PER_RECONFIG = 13;
    localparam int          LOCK_MIN = 200;    // Outlasts the next command byte
    localparam int unsigned RANDOM_SEED = 32'he71d_79e0;

    logic         clk;
    logic         reset_state_machine;
    logic         usb_uart_rx;
    logic         transaction_complete;
    logic         clk_locked;
    logic         usb_uart_tx;
    logic         start;
    logic         address_inc;
    access_mode_t read_write;
    port_mask_t   port_mask;
    burst_len_t   length;
    drp_addr_t    clk_addr;
    drp_data_t    clk_data;
    logic         transact;

    bit aborted;
    int timeout_count;

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    hbm_test_controller i_hbm_test_controller
    (
        .clk                  (clk),
        .reset_state_machine  (reset_state_machine),
        .usb_uart_rx          (usb_uart_rx),
        .transaction_complete (transaction_complete),
        .clk_locked           (clk_locked),
        .usb_uart_tx          (usb_uart_tx),
        .start                (start),
        .address_inc          (address_inc),
        .read_write           (read_write),
        .port_mask            (port_mask),
        .length               (length),
        .clk_addr             (clk_addr),
        .clk_data             (clk_data),
        .transact             (transact)
    );

    reply_checker i_reply_checker
    (
        .clk                  (clk),
        .reset_state_machine  (reset_state_machine),
        .usb_uart_tx          (usb_uart_tx),
        .transact             (transact),
        .clk_addr             (clk_addr),
        .clk_data             (clk_data),
        .start                (start),
        .address_inc          (address_inc),
        .read_write           (read_write),
        .port_mask            (port_mask),
        .length               (length)
    );

    ////////////////////////////////////////////////////////////
    // Clock generator register port

    initial
    begin : register_port
        int unsigned seed_draw;
        int          writes_seen;
        int          delay;
        logic        transact_q;
        seed_draw = $urandom(RANDOM_SEED);  // All random delays come from here
        transaction_complete = 1'b0;
        clk_locked = 1'b0;
        writes_seen = 0;
        transact_q = 1'b0;
        forever
        begin
            @(negedge clk);
            if (transact === 1'b1 && transact_q !== 1'b1)
            begin
                if (writes_seen == 0)
                    clk_locked = 1'b0;  // New reconfiguration
                delay = 1 + $urandom % 6;
                repeat (delay) @(negedge clk);
                transaction_complete = 1'b1;
                @(negedge clk);
                transaction_complete = 1'b0;
                writes_seen++;
                if (writes_seen == WRITES_PER_RECONFIG)
                begin
                    writes_seen = 0;
                    delay = LOCK_MIN + $urandom % 64;
                    repeat (delay) @(negedge clk);
                    clk_locked = 1'b1;
                end
            end
            transact_q = transact;
        end
    end

    // Start, 8 data bits LSB first, stop, then one idle bit
    task automatic send_byte(input byte_t value);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, value, 1'b0};
        for (i = 0; i < 10; i++)
        begin
            usb_uart_rx = frame[i];
            repeat (BIT_CLKS) @(negedge clk);
        end
        repeat (BIT_CLKS) @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // Trace runner

    initial
    begin : run_trace
        int          fd;
        int          fields;
        string       text_line;
        string       tag;
        logic [7:0]  tx_value;
        logic [7:0]  reply_flag;
        logic [7:0]  reply_value;
        logic [31:0] e_start;
        logic [31:0] e_mode;
        logic [31:0] e_inc;
        logic [31:0] e_mask;
        logic [31:0] e_len;
        logic [31:0] e_addr;
        logic [31:0] e_data;
        bit          timed_out;
        aborted = 1'b0;
        timeout_count = 0;
        reset_state_machine = 1'b1;
        usb_uart_rx = 1'b1;  // Idle line
        repeat (2) @(negedge clk);
        reset_state_machine = 1'b0;

        fd = $fopen("tb/command_trace.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open tb/command_trace.txt");
            aborted = 1'b1;
        end
        while (!aborted && $fgets(text_line, fd) > 0)
        begin
            fields = $sscanf(text_line, "%s", tag);
            if (fields != 1 || tag.substr(0, 0) == "#")
                continue;
            if (tag == "B")
            begin
                fields = $sscanf(text_line, "B %h %h %h", tx_value, reply_flag, reply_value);
                if (reply_flag != 8'h00)
                    i_reply_checker.expect_reply(reply_value);
                send_byte(tx_value);
            end
            else if (tag == "S")
            begin
                fields = $sscanf(text_line, "S %h %h %h %h %h",
                                 e_start, e_mode, e_inc, e_mask, e_len);
                i_reply_checker.wait_replies(timed_out);
                if (timed_out)
                begin
                    $display("Timeout at %0d ns, an expected reply never arrived", $time);
                    timeout_count++;
                    aborted = 1'b1;
                end
                else
                    i_reply_checker.check_settings(e_start[0], e_mode[2:0], e_inc[0],
                                                   e_mask, e_len[3:0]);
            end
            else if (tag == "D")
            begin
                fields = $sscanf(text_line, "D %h %h", e_addr, e_data);
                i_reply_checker.check_write(e_addr[10:0], e_data[15:0], timed_out);
                if (timed_out)
                begin
                    $display("Timeout at %0d ns, no register-port write to 0x%03h",
                             $time, e_addr[10:0]);
                    timeout_count++;
                    aborted = 1'b1;
                end
            end
            else
            begin
                $display("Trace line not understood: %s", text_line);
                aborted = 1'b1;
            end
        end

        if (!aborted)
        begin
            i_reply_checker.wait_replies(timed_out);
            if (timed_out)
            begin
                $display("Timeout at %0d ns, final replies never arrived", $time);
                timeout_count++;
                aborted = 1'b1;
            end
            repeat (22 * BIT_CLKS) @(negedge clk);  // A stray reply would be done by now
            i_reply_checker.report_leftovers();
        end
        if (fd != 0)
            $fclose(fd);

        $display("Errors: %0d mismatched, %0d missing or extra, %0d timeouts",
                 i_reply_checker.mismatch_count, i_reply_checker.lost_count, timeout_count);
        if (aborted || i_reply_checker.mismatch_count != 0 || i_reply_checker.lost_count != 0)
            $display("Test failed");
        else
            $display("Test completed successfully");
        $finish;
    end

endmodule

// File: project.f
logic/hbm_ctrl_pkg.sv
logic/uart_receiver.sv
logic/settings_registers.sv
logic/clock_reconfig_sequencer.sv
logic/reply_transmitter.sv
logic/hbm_test_controller.sv
tb/reply_checker.sv
tb/tb_top.sv

// File: tb/command_trace.txt
# B <byte> <reply 1|0> <reply>  S <start> <read_write> <address_inc> <port_mask> <length>
# D <register address> <word>   all values hex
S 0 0 0 00000000 f
B 30 1 41
S 1 0 0 00000000 f
B 31 1 42
S 0 0 0 00000000 f
B 32 1 43
S 0 1 0 00000000 f
B 35 1 46
S 0 3 0 00000000 f
B 36 1 47
S 0 4 0 00000000 f
B 33 1 44
S 0 0 0 00000000 f
B 37 1 48
S 0 0 1 00000000 f
B 38 1 49
S 0 0 0 00000000 f
# Data bytes that look like clock commands
B 39 0 00
B 3c 0 00
B 30 0 00
B 40 0 00
B 3e 1 4a
S 0 0 0 3c30403e f
B 3a 0 00
B 3d 1 4c
S 0 0 0 3c30403e d
B 3b 0 00
B 2f 0 00
S 0 0 0 3c30403e d
B 30 1 41
B 37 1 48
B 32 1 43
S 1 1 1 3c30403e d
B 40 1 4b
S 0 0 0 00000000 f
B 30 1 41
B 3c 1 4e
D 304 1041
D 308 0000
D 30c 1105
D 310 0080
D 33c 1041
D 340 1187
D 344 0080
D 348 02ee
D 34c 7c01
D 350 7fe9
D 354 0900
D 358 8890
D 35c 0003
# Stop lands while the lock is awaited
B 31 0 00
B 3b 0 00
S 1 0 0 00000000 f
B 3d 1 4f
D 304 1041
D 308 0000
D 30c 1105
D 310 0080
D 33c 1041
D 340 1105
D 344 0080
D 348 03e8
D 34c 6401
D 350 67e9
D 354 0900
D 358 1890
D 35c 0003
B 39 0 00
B 2f 0 00
S 1 0 0 00000000 f
B 3e 1 50
D 304 1082
D 308 0000
D 30c 1249
D 310 0000
D 33c 1041
D 340 1187
D 344 0080
D 348 02ee
D 34c 7c01
D 350 7fe9
D 354 0900
D 358 8890
D 35c 0003
B 3a 0 00
B 3b 0 00
S 1 0 0 00000000 f
